// ==== sources.f ====
display_pkg.sv
display_regs.sv
bitplane_shifters.sv
color_table.sv
ham_generator.sv
video_top.sv
tb_video_top.sv

// ==== Makefile ====
# Verilator flow for the display encoder
#   make lint    lint the RTL top level
#   make sim     build and run the testbench, pass if the log holds the pass line
#   make clean   remove build output and log
# every variable below can be overridden on the command line

VERILATOR  ?= verilator
FILELIST   ?= sources.f
TB_TOP     ?= tb_video_top
RTL_TOP    ?= video_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= STATUS: PASS
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

SOURCES     := $(shell cat $(FILELIST))
RTL_SOURCES := $(filter-out $(TB_TOP).sv,$(SOURCES))
SIM_BIN     := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_video_top.sv ====
// --------------------------------------------------------------------------
// testbench for the display encoder top level
// programs palette, window and plane words over wishbone, runs lines in
// palette, ehb, ham6 and masked modes, checks every pixel shown under de
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_video_top;
  import display_pkg::*;

  localparam int ACK_TIMEOUT  = 16;    // cycles
  localparam int LINE_TIMEOUT = 1000;  // strobe to de edge, cycles
  localparam int LINE_PIXELS  = 24;    // window 0x0e8..0x100

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  reg_addr_t   wb_adr;
  logic [15:0] wb_dat_w;
  logic [15:0] wb_dat_r;
  logic        wb_ack;
  logic        pix_en;
  logic        strhor;
  logic        blank;
  logic [3:0]  red;
  logic [3:0]  green;
  logic [3:0]  blue;
  logic        de;

  logic [11:0] pal [NUM_COLORS];    // palette as written
  logic [15:0] words [NUM_PLANES];  // plane words for the next line
  logic [11:0] exp_q [$];           // pixels still to come, in order
  string       test_name = "reset";
  integer      seed = 92340;
  int          errors = 0;
  int          checks = 0;

  video_top dut (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .pix_en(pix_en), .strhor(strhor), .blank(blank),
    .red(red), .green(green), .blue(blue), .de(de)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 125 MHz
  end

  task automatic compare_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
    end
  endtask

  // one classic cycle, held through the ack edge
  task automatic bus_cycle(input logic we, input reg_addr_t adr, input logic [15:0] wdata,
                           output logic [15:0] rdata);
    int n;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < ACK_TIMEOUT);
    if (!wb_ack) begin
      errors++;
      $display("ERROR: no bus acknowledge for register %h", adr);
    end
    rdata = wb_dat_r;  // read data valid in the ack cycle
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input reg_addr_t adr, input logic [15:0] data);
    logic [15:0] unused_rd;
    bus_cycle(1'b1, adr, data, unused_rd);
  endtask

  task automatic wb_read(input reg_addr_t adr, output logic [15:0] data);
    bus_cycle(1'b0, adr, 16'h0000, data);
  endtask

  task automatic write_color(input int i, input logic [15:0] word);
    wb_write(reg_addr_t'(COLOR00_ADR + i), word);
    pal[i] = word[11:0];  // upper nibble has no storage
  endtask

  task automatic fill_plane_words(input int first);
    logic [31:0] rnd;
    for (int p = first; p < NUM_PLANES; p++) begin
      rnd = $random(seed);
      words[p] = rnd[15:0];
    end
  endtask

  task automatic wait_de(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (de !== level && n < LINE_TIMEOUT);
    if (de !== level) begin
      errors++;
      $display("ERROR: timeout in %s waiting for display enable to go %0d", test_name, level);
    end
  endtask

  // ------------------------------------------------------------------------
  // reference model of one pixel
  // ------------------------------------------------------------------------
  function automatic logic [11:0] expected_color(input logic ham, input int nplanes,
                                                 input logic [5:0] raw, input logic [11:0] prev);
    logic [5:0]  idx;
    logic [11:0] c;
    for (int i = 0; i < 6; i++)
      idx[i] = (i < nplanes) ? raw[i] : 1'b0;  // unused planes read as zero
    if (ham && nplanes == 6) begin
      case (idx[5:4])
        2'd0:    c = pal[idx[3:0]];                        // set from palette
        2'd1:    c = {prev[11:4], idx[3:0]};               // new blue
        2'd2:    c = {idx[3:0], prev[7:0]};                // new red
        default: c = {prev[11:8], idx[3:0], prev[3:0]};    // new green
      endcase
    end else begin
      c = pal[idx[4:0]];
      if (!ham && nplanes == 6 && idx[5])
        c = {c[11:8] >> 1, c[7:4] >> 1, c[3:0] >> 1};  // half brite
    end
    return c;
  endfunction

  // load the words, queue the expected line, run it and check the border after
  task automatic run_line(input string name, input logic ham, input int nplanes);
    logic [5:0]  raw;
    logic [11:0] c;
    logic [11:0] prev;
    logic [2:0]  bpu;
    bpu = 3'(nplanes);
    wb_write(BPLCON0_ADR, {1'b0, bpu, ham, 11'd0});
    for (int p = 1; p < NUM_PLANES; p++)
      wb_write(reg_addr_t'(BPL1DAT_ADR + p), words[p]);
    wb_write(BPL1DAT_ADR, words[0]);  // plane 1 last, it moves all words
    prev = pal[0];                    // ham hold starts from entry 0
    for (int k = 0; k < LINE_PIXELS; k++) begin
      raw = '0;
      if (k < 16)
        for (int p = 0; p < NUM_PLANES; p++)
          raw[p] = words[p][15-k];  // msb first
      c = expected_color(ham, nplanes, raw, prev);
      exp_q.push_back(c);
      prev = c;
    end
    test_name = name;
    @(negedge clk);
    strhor = 1'b1;
    @(negedge clk);
    strhor = 1'b0;
    wait_de(1'b1);
    wait_de(1'b0);
    if (exp_q.size() != 0) begin
      errors++;
      $display("ERROR: %0d pixels of %s were never displayed", exp_q.size(), name);
      exp_q.delete();
    end
    compare_value({name, " border"}, {4'h0, pal[0]}, {4'h0, red, green, blue});
  endtask

  // pixel compare, outputs sampled before the edge updates them
  always @(posedge clk) begin : compare_pixels
    logic [11:0] want;
    if (de === 1'b1) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR: display enable high in %s with no pixel expected", test_name);
      end else begin
        want = exp_q.pop_front();
        compare_value(test_name, {4'h0, want}, {4'h0, red, green, blue});
      end
    end
  end

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial begin
    logic [15:0] d;
    logic [31:0] rnd;
    logic [3:0]  prime;
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    pix_en   = 1'b0;  // beam counter frozen during setup
    strhor   = 1'b0;
    blank    = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    compare_value("reset de", 16'd0, {15'd0, de});
    compare_value("reset ack", 16'd0, {15'd0, wb_ack});
    compare_value("reset rgb", 16'd0, {4'h0, red, green, blue});

    test_name = "registers";
    wb_read(DENISEID_ADR, d);
    compare_value("id read", DENISE_ID, d);
    wb_write(BPLCON0_ADR, 16'h6800);
    wb_read(BPLCON0_ADR, d);
    compare_value("bplcon0 read", 16'h6800, d);
    wb_write(DIWSTRT_ADR, 16'ha155);
    wb_read(DIWSTRT_ADR, d);
    compare_value("diwstrt read", 16'h0055, d);  // only h0..h7 kept
    wb_write(DIWSTOP_ADR, 16'h7f21);
    wb_read(DIWSTOP_ADR, d);
    compare_value("diwstop read", 16'h0121, d);  // h8 reads as one
    wb_read(BPL1DAT_ADR, d);
    compare_value("unmapped read", 16'h0000, d);

    for (int i = 0; i < NUM_COLORS; i++) begin
      rnd = $random(seed);
      write_color(i, rnd[15:0]);
    end
    wb_write(DIWSTRT_ADR, 16'h00e8);
    wb_write(DIWSTOP_ADR, 16'h0000);  // stop at 0x100
    @(negedge clk);
    pix_en = 1'b1;

    fill_plane_words(0);
    run_line("palette 5 planes", 1'b0, 5);

    fill_plane_words(0);
    words[5] = 16'hcc33;  // both halves of the ehb range
    run_line("ehb", 1'b0, 6);

    // ham codes walk set, blue, red, green
    fill_plane_words(0);
    words[4] = 16'h5555;
    words[5] = 16'h3333;
    run_line("ham6 line 1", 1'b1, 6);
    rnd = $random(seed);
    write_color(0, rnd[15:0]);
    // park a red unlike entry 0 in the hold colour before line 2
    prime = ~pal[0][11:8];
    wb_write(BPL2DAT_ADR, {prime[1], 15'd0});
    wb_write(BPL3DAT_ADR, {prime[2], 15'd0});
    wb_write(BPL4DAT_ADR, {prime[3], 15'd0});
    wb_write(BPL5DAT_ADR, 16'h0000);
    wb_write(BPL6DAT_ADR, 16'h8000);  // red code
    wb_write(BPL1DAT_ADR, {prime[0], 15'd0});
    words[4] = 16'haaaa;  // first pixel modifies entry 0
    words[5] = 16'h6666;
    run_line("ham6 line 2", 1'b1, 6);

    fill_plane_words(0);
    run_line("mask 3 planes a", 1'b0, 3);
    fill_plane_words(3);  // new words only in masked planes
    run_line("mask 3 planes b", 1'b0, 3);

    // whole line under blank
    test_name = "blank";
    @(negedge clk);
    blank  = 1'b1;
    strhor = 1'b1;
    @(negedge clk);
    strhor = 1'b0;
    for (int n = 0; n < 300; n++) begin
      @(negedge clk);
      compare_value("blank de", 16'd0, {15'd0, de});
      compare_value("blank rgb", 16'd0, {4'h0, red, green, blue});
    end
    blank = 1'b0;
    @(negedge clk);
    compare_value("after blank border", {4'h0, pal[0]}, {4'h0, red, green, blue});
    pix_en = 1'b0;

    $display("tb_video_top: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== video_top.sv ====
// --------------------------------------------------------------------------
// display encoder top: register block, shifters, palette and ham generator
// picks ham or palette colour, shows the border colour outside the window,
// blanks and registers the 4:4:4 rgb output with display enable
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module video_top (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    wb_cyc,
  input  wire                    wb_stb,
  input  wire                    wb_we,
  input  wire display_pkg::reg_addr_t wb_adr,
  input  wire [15:0]             wb_dat_w,
  output logic [15:0]            wb_dat_r,
  output logic                   wb_ack,
  input  wire                    pix_en,
  input  wire                    strhor,
  input  wire                    blank,
  output logic [3:0]             red,
  output logic [3:0]             green,
  output logic [3:0]             blue,
  output logic                   de
);
  import display_pkg::*;

  logic        reg_wr;
  reg_addr_t   reg_adr;
  logic [15:0] reg_data;
  logic [2:0]  bpu;
  logic        ham_mode;
  logic        window;
  logic        window_start;
  logic        window_d;   // aligned with the colour registers
  logic        ehb_en;
  logic        ham_sel;
  pixel_u      bpl_pixel;
  pixel_u      clut_pixel;
  rgb12_t      clut_rgb;
  rgb12_t      ham_rgb;
  rgb12_t      out_rgb;

  display_regs u_regs (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .pix_en(pix_en), .strhor(strhor),
    .reg_wr(reg_wr), .reg_adr(reg_adr), .reg_data(reg_data),
    .bpu(bpu), .ham_mode(ham_mode), .window(window), .window_start(window_start)
  );

  bitplane_shifters u_shifters (
    .clk(clk), .reset(reset), .pix_en(pix_en), .window(window),
    .reg_wr(reg_wr), .reg_adr(reg_adr), .reg_data(reg_data),
    .bpu(bpu), .pixel(bpl_pixel)
  );

  // index 0 outside the window gives the border colour
  assign clut_pixel.index = window ? bpl_pixel.index : '0;

  assign ehb_en  = (bpu == FULL_BPU) && !ham_mode;
  assign ham_sel = (bpu == FULL_BPU) && ham_mode;

  color_table u_clut (
    .clk(clk), .pix_en(pix_en),
    .reg_wr(reg_wr), .reg_adr(reg_adr), .reg_data(reg_data),
    .pixel(clut_pixel), .ehb_en(ehb_en), .rgb(clut_rgb)
  );

  ham_generator u_ham (
    .clk(clk), .reset(reset), .pix_en(pix_en), .window_start(window_start),
    .reg_wr(reg_wr), .reg_adr(reg_adr), .reg_data(reg_data),
    .pixel(bpl_pixel), .rgb(ham_rgb)
  );

  // --------------------------------------------------------------------------
  // output stage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset)
      window_d <= 1'b0;
    else if (pix_en)
      window_d <= window;
  end

  assign out_rgb = (ham_sel && window_d) ? ham_rgb : clut_rgb;

  always_ff @(posedge clk) begin
    if (reset) begin
      {red, green, blue} <= '0;
      de                 <= 1'b0;
    end else if (pix_en) begin
      {red, green, blue} <= blank ? 12'h000 : out_rgb;  // blank forces black
      de                 <= window_d & ~blank;
    end
  end

endmodule

`default_nettype wire

// ==== ham_generator.sv ====
// --------------------------------------------------------------------------
// hold-and-modify colour generator for ham6
// keeps its own copy of palette entries 0..15 from the colour writes;
// the held colour restarts at entry 0 when the window opens
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ham_generator (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    pix_en,
  input  wire                    window_start,
  input  wire                    reg_wr,
  input  wire display_pkg::reg_addr_t reg_adr,
  input  wire [15:0]             reg_data,
  input  wire display_pkg::pixel_u pixel,
  output display_pkg::rgb12_t    rgb
);
  import display_pkg::*;

  rgb12_t base_pal [16];  // entries 0..15 only
  rgb12_t hold;
  logic   base_wr;

  // lower half of the colour block
  assign base_wr = reg_wr && (reg_adr[7:4] == COLOR00_ADR[7:4]);

  always_ff @(posedge clk) begin
    if (base_wr)
      base_pal[reg_adr[3:0]] <= reg_data[11:0];
  end

  // colour being modified
  assign hold = window_start ? base_pal[0] : rgb;

  always_ff @(posedge clk) begin
    if (reset) begin
      rgb <= '0;
    end else if (pix_en) begin
      case (pixel.ham.ctl)
        HAM_SET:   rgb <= base_pal[pixel.ham.val];
        HAM_BLUE:  rgb <= {hold[11:4], pixel.ham.val};
        HAM_RED:   rgb <= {pixel.ham.val, hold[7:0]};
        HAM_GREEN: rgb <= {hold[11:8], pixel.ham.val, hold[3:0]};
        default:   rgb <= hold;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== color_table.sv ====
// --------------------------------------------------------------------------
// 32-entry 12-bit colour palette, written over the register strobe
// lookup is registered on pix_en; extra-half-brite halves each component
// when enabled and index bit 5 is set
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module color_table (
  input  wire                    clk,
  input  wire                    pix_en,
  input  wire                    reg_wr,
  input  wire display_pkg::reg_addr_t reg_adr,
  input  wire [15:0]             reg_data,
  input  wire display_pkg::pixel_u pixel,
  input  wire                    ehb_en,
  output display_pkg::rgb12_t    rgb
);
  import display_pkg::*;

  rgb12_t    palette [NUM_COLORS];
  logic      color_wr;
  reg_addr_t color_idx;  // offset from COLOR00
  rgb12_t    entry;

  // colour words occupy one aligned 32-word block
  assign color_wr  = reg_wr && (reg_adr[7:5] == COLOR00_ADR[7:5]);
  assign color_idx = reg_adr - COLOR00_ADR;

  always_ff @(posedge clk) begin
    if (color_wr)
      palette[color_idx[4:0]] <= reg_data[11:0];  // upper nibble unused
  end

  assign entry = palette[pixel.index[4:0]];

  // --------------------------------------------------------------------------
  // lookup
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (pix_en) begin
      if (ehb_en && pixel.index[5])
        rgb <= {1'b0, entry[11:9], 1'b0, entry[7:5], 1'b0, entry[3:1]};  // half brite
      else
        rgb <= entry;
    end
  end

  // decode block must line up with the COLOR00 base
  a_color_range : assert property (@(posedge clk)
    color_wr |-> (color_idx < NUM_COLORS));

endmodule

`default_nettype wire

// ==== bitplane_shifters.sv ====
// --------------------------------------------------------------------------
// six bitplane holding words and their 16-bit shifters
// a BPL1DAT write copies all holding words in; shifting runs msb first on
// pix_en inside the window, planes beyond the latched count read as zero
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bitplane_shifters (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    pix_en,
  input  wire                    window,
  input  wire                    reg_wr,
  input  wire display_pkg::reg_addr_t reg_adr,
  input  wire [15:0]             reg_data,
  input  wire [2:0]              bpu,
  output display_pkg::pixel_u    pixel
);
  import display_pkg::*;

  logic [15:0]      bpl_hold  [NUM_PLANES];  // written by the host
  logic [15:0]      bpl_shift [NUM_PLANES];
  logic [BPU_W-1:0] l_bpu;                   // plane count for current word
  logic             load_pend;

  // holding registers
  always_ff @(posedge clk) begin
    if (reg_wr) begin
      case (reg_adr)
        BPL1DAT_ADR: bpl_hold[0] <= reg_data;
        BPL2DAT_ADR: bpl_hold[1] <= reg_data;
        BPL3DAT_ADR: bpl_hold[2] <= reg_data;
        BPL4DAT_ADR: bpl_hold[3] <= reg_data;
        BPL5DAT_ADR: bpl_hold[4] <= reg_data;
        BPL6DAT_ADR: bpl_hold[5] <= reg_data;
        default: ;
      endcase
    end
  end

  // copy one cycle after the plane-1 write, once its holding word is in
  always_ff @(posedge clk) begin
    if (reset)
      load_pend <= 1'b0;
    else
      load_pend <= reg_wr && (reg_adr == BPL1DAT_ADR);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_PLANES; i++)
        bpl_shift[i] <= '0;
      l_bpu <= '0;
    end else if (load_pend) begin
      bpl_shift <= bpl_hold;
      l_bpu     <= bpu;  // mid-line BPLCON0 writes wait for the next word
    end else if (pix_en && window) begin
      for (int i = 0; i < NUM_PLANES; i++)
        bpl_shift[i] <= {bpl_shift[i][14:0], 1'b0};  // zeros after 16 pixels
    end
  end

  // serial pixel from the msbs with plane masking
  always_comb begin
    for (int i = 0; i < NUM_PLANES; i++)
      pixel.index[i] = (i < l_bpu) ? bpl_shift[i][15] : 1'b0;
  end

endmodule

`default_nettype wire

// ==== display_regs.sv ====
// --------------------------------------------------------------------------
// wishbone classic slave with single-cycle ack, BPLCON0 and window limits,
// horizontal beam counter and display window flag
// hands a one-cycle write strobe to the other blocks for their own decode
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module display_regs (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    wb_cyc,
  input  wire                    wb_stb,
  input  wire                    wb_we,
  input  wire display_pkg::reg_addr_t wb_adr,
  input  wire [15:0]             wb_dat_w,
  output logic [15:0]            wb_dat_r,
  output logic                   wb_ack,
  input  wire                    pix_en,
  input  wire                    strhor,
  output logic                   reg_wr,
  output display_pkg::reg_addr_t reg_adr,
  output logic [15:0]            reg_data,
  output logic [2:0]             bpu,
  output logic                   ham_mode,
  output logic                   window,
  output logic                   window_start
);
  import display_pkg::*;

  logic [15:0]       bplcon0;
  logic [HPOS_W-1:0] hdiwstrt;  // bit 8 always zero on ocs
  logic [HPOS_W-1:0] hdiwstop;  // bit 8 always one on ocs
  logic [HPOS_W-1:0] hpos;      // horizontal beam counter
  logic              win_open;

  // ack one cycle after cyc & stb, then drop so the next cycle is free
  always_ff @(posedge clk) begin
    if (reset)
      wb_ack <= 1'b0;
    else
      wb_ack <= wb_cyc & wb_stb & ~wb_ack;
  end

  // write strobe lands on the ack edge, master still holds adr and data
  assign reg_wr   = wb_ack & wb_we;
  assign reg_adr  = wb_adr;
  assign reg_data = wb_dat_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      bplcon0  <= '0;
      hdiwstrt <= '0;
      hdiwstop <= 9'h100;
    end else if (reg_wr) begin
      case (reg_adr)
        BPLCON0_ADR: bplcon0  <= reg_data;
        DIWSTRT_ADR: hdiwstrt <= {1'b0, reg_data[7:0]};
        DIWSTOP_ADR: hdiwstop <= {1'b1, reg_data[7:0]};  // h8 forced high
        default: ;
      endcase
    end
  end

  assign bpu      = bplcon0[BPU_HI:BPU_LO];
  assign ham_mode = bplcon0[HAM_BIT];

  // readback mux, valid in the ack cycle
  always_comb begin
    case (wb_adr)
      DENISEID_ADR: wb_dat_r = DENISE_ID;
      BPLCON0_ADR:  wb_dat_r = bplcon0;
      DIWSTRT_ADR:  wb_dat_r = {7'd0, hdiwstrt};
      DIWSTOP_ADR:  wb_dat_r = {7'd0, hdiwstop};
      default:      wb_dat_r = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // beam counter and window
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset)
      hpos <= '0;
    else if (strhor)
      hpos <= HPOS_START;  // line start
    else if (pix_en)
      hpos <= hpos + 1'b1;
  end

  assign win_open = (hpos == hdiwstrt);

  always_ff @(posedge clk) begin
    if (reset) begin
      window       <= 1'b0;
      window_start <= 1'b0;
    end else begin
      window_start <= pix_en & win_open;  // first windowed pixel cycle
      if (pix_en) begin
        if (win_open)
          window <= 1'b1;
        else if (hpos == hdiwstop)
          window <= 1'b0;
      end
    end
  end

  // adr, we and data stay put from the request up to the ack edge
  a_req_held : assert property (@(posedge clk) disable iff (reset)
    (wb_cyc && wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we)
      && $stable(wb_dat_w)));

  // master keeps the request up until ack
  a_ack_in_cycle : assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> (wb_cyc && wb_stb));

endmodule

`default_nettype wire

// ==== display_pkg.sv ====
// --------------------------------------------------------------------------
// shared definitions for the display encoder: register word addresses,
// BPLCON0 field positions, widths, colour and pixel types
// imported by every block of the encoder
// --------------------------------------------------------------------------
`default_nettype none

package display_pkg;

  // register word address (bus address bits 8 to 1)
  typedef logic [7:0] reg_addr_t;

  // --------------------------------------------------------------------------
  // register map
  // --------------------------------------------------------------------------
  localparam reg_addr_t DIWSTRT_ADR  = 8'h47;  // 0x08e
  localparam reg_addr_t DIWSTOP_ADR  = 8'h48;  // 0x090
  localparam reg_addr_t DENISEID_ADR = 8'h3e;  // 0x07c
  localparam reg_addr_t BPLCON0_ADR  = 8'h80;  // 0x100
  localparam reg_addr_t BPL1DAT_ADR  = 8'h88;  // 0x110, load trigger
  localparam reg_addr_t BPL2DAT_ADR  = 8'h89;
  localparam reg_addr_t BPL3DAT_ADR  = 8'h8a;
  localparam reg_addr_t BPL4DAT_ADR  = 8'h8b;
  localparam reg_addr_t BPL5DAT_ADR  = 8'h8c;
  localparam reg_addr_t BPL6DAT_ADR  = 8'h8d;
  localparam reg_addr_t COLOR00_ADR  = 8'hc0;  // 0x180, 32 words from here

  localparam logic [15:0] DENISE_ID = 16'hffff;  // ocs part

  // sizes
  localparam int NUM_PLANES = 6;
  localparam int NUM_COLORS = 32;
  localparam int BPU_W      = 3;
  localparam int HPOS_W     = 9;

  localparam logic [HPOS_W-1:0] HPOS_START = 9'd2;  // first count after strobe

  // --------------------------------------------------------------------------
  // BPLCON0 decoding
  // --------------------------------------------------------------------------
  localparam int BPU_HI  = 14;  // plane count field
  localparam int BPU_LO  = 12;
  localparam int HAM_BIT = 11;

  localparam logic [BPU_W-1:0] FULL_BPU = 3'd6;  // ehb and ham6 both need six planes

  // 4 bits each of red, green, blue
  typedef logic [11:0] rgb12_t;

  // one pixel word, read as a palette index or as a ham code/value pair
  typedef union packed {
    logic [5:0] index;
    struct packed {
      logic [1:0] ctl;
      logic [3:0] val;
    } ham;
  } pixel_u;

  // ham control codes
  localparam logic [1:0] HAM_SET   = 2'b00;  // palette lookup of low four bits
  localparam logic [1:0] HAM_BLUE  = 2'b01;
  localparam logic [1:0] HAM_RED   = 2'b10;
  localparam logic [1:0] HAM_GREEN = 2'b11;

endpackage

`default_nettype wire
